//--- verilog/stomp_pkg.sv
/*
 * Stomp control shared types
 * Holds the address, reorder buffer and miss report types together with
 * the recovery state encoding used by every block of the stomp unit
 */
package stomp_pkg;

	// ==========================================================
	// sizes
	// ==========================================================

	// default reorder buffer depth used by the top level parameter
	localparam int ROB_ENTRIES = 8;

	// fetch, mux, decode and rename make up the in-order front end
	localparam int NUM_STAGES = 4;

	// ==========================================================
	// basic types
	// ==========================================================

	// one instruction address
	typedef logic [31:0] pc_t;

	// index of an entry in the reorder buffer
	typedef logic [2:0] rob_ndx_t;

	// one reorder buffer entry as seen by the squash logic
	// sn grows with program order so a larger sn is a younger instruction
	typedef struct packed {
		logic       v;
		logic [7:0] sn;
		logic [2:0] grp;
		logic [4:0] bno;
		logic       is_br;
	} rob_entry_t;

	// the miss report as it arrives on the handshake
	typedef struct packed {
		pc_t        target;
		rob_ndx_t   id;
		logic [4:0] keep_bno;
		logic       taken;
	} miss_t;

	// ==========================================================
	// recovery states
	// ==========================================================

	// the sequencer walks restore and two done states before going idle
	typedef enum logic [1:0] {
		bs_idle,
		bs_restore,
		bs_done1,
		bs_done2
	} branch_state_t;

endpackage

//--- verilog/branch_recovery.sv
/*
 * Branch recovery sequencer
 * Accepts a miss report over a four-phase req/ack handshake and steps
 * through the checkpoint restore states, holding the report meanwhile
 */
module branch_recovery (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     miss_req,
	input  stomp_pkg::miss_t         miss,
	output logic                     miss_ack,
	output stomp_pkg::branch_state_t branch_state,
	output stomp_pkg::miss_t         miss_q
);

	// a request is taken only when idle and the previous ack has dropped
	// so a requester that holds req high is not accepted twice
	logic accept;

	assign accept = miss_req && !miss_ack && branch_state == stomp_pkg::bs_idle;

	// ==========================================================
	// restore sequence
	// ==========================================================

	// three cycles of recovery follow every accepted miss
	always_ff @(posedge clk) begin
		if (rst) begin
			branch_state <= stomp_pkg::bs_idle;
		end else begin
			case (branch_state)
				stomp_pkg::bs_idle: begin
					if (accept) begin
						branch_state <= stomp_pkg::bs_restore;
					end
				end
				stomp_pkg::bs_restore: branch_state <= stomp_pkg::bs_done1;
				stomp_pkg::bs_done1:   branch_state <= stomp_pkg::bs_done2;
				default:               branch_state <= stomp_pkg::bs_idle;
			endcase
		end
	end

	// ==========================================================
	// handshake
	// ==========================================================

	// ack rises with the accept and falls once req is seen low
	always_ff @(posedge clk) begin
		if (rst) begin
			miss_ack <= 1'b0;
		end else if (accept) begin
			miss_ack <= 1'b1;
		end else if (!miss_req) begin
			miss_ack <= 1'b0;
		end
	end

	// the report stays put for the whole recovery
	always_ff @(posedge clk) begin
		if (accept) begin
			miss_q <= miss;
		end
	end

	// an ack may only appear as the answer to a request seen while idle
	ack_from_idle_a: assert property (@(posedge clk) disable iff (rst)
		$rose(miss_ack) |-> $past(branch_state) == stomp_pkg::bs_idle)
		else $error("miss_ack rose outside bs_idle");

	// recovery always enters through the restore state
	idle_exit_a: assert property (@(posedge clk) disable iff (rst)
		branch_state == stomp_pkg::bs_idle |=>
			branch_state inside {stomp_pkg::bs_idle, stomp_pkg::bs_restore})
		else $error("branch_state left bs_idle for a state other than bs_restore");

endmodule

//--- verilog/front_stomp.sv
/*
 * Front-end stomp waterfall
 * Marks fetch, mux, decode and rename as stomped after a branch miss and
 * releases each stage once the corrected target PC reaches it
 */
module front_stomp (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     advance,
	input  stomp_pkg::branch_state_t branch_state,
	input  stomp_pkg::miss_t         miss_q,
	input  stomp_pkg::pc_t           pc_fet,
	input  stomp_pkg::pc_t           pc_mux,
	input  stomp_pkg::pc_t           pc_dec,
	input  stomp_pkg::pc_t           pc_ren,
	output logic                     stomp_fet,
	output logic                     stomp_mux,
	output logic                     stomp_dec,
	output logic                     stomp_ren
);

	// stage order in every vector below is fetch at bit 0 up to rename
	stomp_pkg::pc_t [stomp_pkg::NUM_STAGES-1:0] stage_pc;
	stomp_pkg::pc_t [stomp_pkg::NUM_STAGES-1:0] tgt_pc;
	logic [stomp_pkg::NUM_STAGES-1:0] tgt_v;
	logic [stomp_pkg::NUM_STAGES-1:0] flag;
	logic [stomp_pkg::NUM_STAGES-1:0] stomp;
	logic active;
	logic active_q;
	logic stomp_start;

	assign stage_pc = {pc_ren, pc_dec, pc_mux, pc_fet};

	// ==========================================================
	// start of recovery
	// ==========================================================

	// any state other than idle means the front end holds wrong-path work
	assign active = branch_state != stomp_pkg::bs_idle;

	// the edge is not gated by advance so a stall cannot delay the squash
	always_ff @(posedge clk) begin
		if (rst) begin
			active_q <= 1'b0;
		end else begin
			active_q <= active;
		end
	end

	assign stomp_start = active && !active_q;

	// ==========================================================
	// stomp outputs
	// ==========================================================

	// a stage is released when its PC matches the target in its chain slot
	always_comb begin
		for (int i = 0; i < stomp_pkg::NUM_STAGES; i++) begin
			stomp[i] = stomp_start || (flag[i] && !(tgt_v[i] && stage_pc[i] == tgt_pc[i]));
		end
	end

	assign stomp_fet = stomp[0];
	assign stomp_mux = stomp[1];
	assign stomp_dec = stomp[2];
	assign stomp_ren = stomp[3];

	// ==========================================================
	// flags and target chain
	// ==========================================================

	// at power-up the empty pipeline counts as invalid so every flag is set
	// each advance hands a stage the stomp state of the stage before it
	// and the fetch stage always starts clean with freshly fetched work
	always_ff @(posedge clk) begin
		if (rst) begin
			flag  <= '1;
			tgt_v <= '0;
		end else if (stomp_start) begin
			flag  <= '1;
			tgt_v <= {{(stomp_pkg::NUM_STAGES-1){1'b0}}, 1'b1};
		end else if (advance) begin
			flag  <= {stomp[stomp_pkg::NUM_STAGES-2:0], 1'b0};
			tgt_v <= {tgt_v[stomp_pkg::NUM_STAGES-2:0], 1'b0};
		end
	end

	// the corrected target walks down the pipe alongside the instructions
	always_ff @(posedge clk) begin
		if (stomp_start) begin
			tgt_pc[0] <= miss_q.target;
		end else if (advance) begin
			tgt_pc[stomp_pkg::NUM_STAGES-1:1] <= tgt_pc[stomp_pkg::NUM_STAGES-2:0];
		end
	end

	// a stall has to freeze the whole waterfall
	stall_hold_a: assert property (@(posedge clk) disable iff (rst)
		(!advance && !stomp_start) |=> ($stable(tgt_v) && $stable(flag)))
		else $error("stomp chain shifted while advance was low");

endmodule

//--- verilog/rob_stomp.sv
/*
 * Reorder buffer squash bitmap
 * Computes one registered stomp bit per ROB entry during recovery, with
 * same-group entries optionally kept for copy-target backout
 */
module rob_stomp #(
	parameter int rob_entries     = stomp_pkg::ROB_ENTRIES,
	parameter bit support_backout = 1'b1
) (
	input  logic                                   clk,
	input  logic                                   rst,
	input  stomp_pkg::branch_state_t               branch_state,
	input  stomp_pkg::miss_t                       miss_q,
	input  stomp_pkg::rob_entry_t [rob_entries-1:0] rob,
	output logic [rob_entries-1:0]                 rob_stomp_map
);

	// the entry of the mispredicted branch itself
	stomp_pkg::rob_entry_t br;
	logic active;
	logic backout;
	logic [rob_entries-1:0] map_d;

	assign br = rob[miss_q.id];

	// squashing runs only through the first two recovery states
	assign active = branch_state inside {stomp_pkg::bs_restore, stomp_pkg::bs_done1};

	// a not-taken branch keeps its group mates even without backout
	// because they are the correct fall-through path
	assign backout = support_backout || (!miss_q.taken && br.is_br);

	// ==========================================================
	// per-entry rule
	// ==========================================================

	// younger valid entries on another branch number are squashed
	// entries tagged with keep_bno belong to the surviving path
	// a younger entry in the branch's own fetch group is spared when
	// backout applies so its target mappings can be turned into copies
	always_comb begin
		for (int i = 0; i < rob_entries; i++) begin
			map_d[i] = active
				&& rob[i].v
				&& rob[i].sn > br.sn
				&& rob[i].bno != miss_q.keep_bno
				&& !(backout && rob[i].grp == br.grp);
		end
	end

	// the bitmap fans out widely so it leaves from a register
	always_ff @(posedge clk) begin
		if (rst) begin
			rob_stomp_map <= '0;
		end else begin
			rob_stomp_map <= map_d;
		end
	end

	// nothing may be squashed once the sequencer is back to idle
	idle_clear_a: assert property (@(posedge clk) disable iff (rst)
		branch_state == stomp_pkg::bs_idle |=> rob_stomp_map == '0)
		else $error("ROB stomp bitmap set after bs_idle");

endmodule

//--- verilog/stomp_unit.sv
/*
 * Stomp unit top level
 * Joins the miss handshake and recovery sequencer with the front-end
 * stomp waterfall and the reorder buffer squash bitmap
 */
module stomp_unit #(
	parameter int rob_entries     = stomp_pkg::ROB_ENTRIES,
	parameter bit support_backout = 1'b1
) (
	input  logic                                   clk,
	input  logic                                   rst,
	input  logic                                   miss_req,
	input  stomp_pkg::miss_t                       miss,
	output logic                                   miss_ack,
	input  logic                                   advance,
	input  stomp_pkg::pc_t                         pc_fet,
	input  stomp_pkg::pc_t                         pc_mux,
	input  stomp_pkg::pc_t                         pc_dec,
	input  stomp_pkg::pc_t                         pc_ren,
	input  stomp_pkg::rob_entry_t [rob_entries-1:0] rob,
	output logic                                   stomp_fet,
	output logic                                   stomp_mux,
	output logic                                   stomp_dec,
	output logic                                   stomp_ren,
	output logic [rob_entries-1:0]                 rob_stomp_map
);

	// recovery state and the held miss report feed both squash blocks
	stomp_pkg::branch_state_t branch_state;
	stomp_pkg::miss_t miss_q;

	branch_recovery recovery_i (
		.clk          (clk),
		.rst          (rst),
		.miss_req     (miss_req),
		.miss         (miss),
		.miss_ack     (miss_ack),
		.branch_state (branch_state),
		.miss_q       (miss_q)
	);

	front_stomp front_i (
		.clk          (clk),
		.rst          (rst),
		.advance      (advance),
		.branch_state (branch_state),
		.miss_q       (miss_q),
		.pc_fet       (pc_fet),
		.pc_mux       (pc_mux),
		.pc_dec       (pc_dec),
		.pc_ren       (pc_ren),
		.stomp_fet    (stomp_fet),
		.stomp_mux    (stomp_mux),
		.stomp_dec    (stomp_dec),
		.stomp_ren    (stomp_ren)
	);

	rob_stomp #(
		.rob_entries     (rob_entries),
		.support_backout (support_backout)
	) rob_i (
		.clk           (clk),
		.rst           (rst),
		.branch_state  (branch_state),
		.miss_q        (miss_q),
		.rob           (rob),
		.rob_stomp_map (rob_stomp_map)
	);

endmodule

//--- testbench/stomp_tb.sv
/*
 * Stomp unit testbench
 * Applies a table of miss reports, ROB images and front-end steps and
 * checks every cycle against a reference model of the squash rules
 */
module stomp_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int rob_n = stomp_pkg::ROB_ENTRIES;
	localparam int stages = stomp_pkg::NUM_STAGES;
	localparam bit backout_on = 1'b1;
	localparam stomp_pkg::pc_t idle_pc = 32'hdead_0000;

	typedef stomp_pkg::rob_entry_t [rob_n-1:0] rob_img_t;

	// one table row holds the miss report, the source of its ROB image and
	// per step the advance bit and whether fetch holds the corrected target
	typedef struct packed {
		stomp_pkg::miss_t m;
		logic rand_rob;
		logic [7:0] adv;
		logic [7:0] hit;
	} case_t;

	logic clk = 1'b0;
	logic rst;
	logic miss_req;
	stomp_pkg::miss_t miss;
	logic miss_ack;
	logic advance;
	stomp_pkg::pc_t pc_fet, pc_mux, pc_dec, pc_ren;
	rob_img_t rob;
	logic stomp_fet, stomp_mux, stomp_dec, stomp_ren;
	logic [rob_n-1:0] rob_stomp_map;

	case_t table_q[$];
	rob_img_t cur_rob;
	stomp_pkg::miss_t cur_miss;
	logic shift_pcs;
	logic [31:0] rng = 32'd83897;
	int cycles = 0;
	int limit = 100;
	int checks = 0;
	int errors = 0;

	// reference model of what the DUT registers should contain
	stomp_pkg::branch_state_t m_state;
	logic m_ack;
	logic [rob_n-1:0] m_map;
	logic [stages-1:0] m_flag;
	logic [stages-1:0] m_tv;
	stomp_pkg::pc_t m_tpc [stages];
	stomp_pkg::miss_t m_miss;

	stomp_unit #(
		.rob_entries     (rob_n),
		.support_backout (backout_on)
	) dut_i (.*);

	always #20 clk = ~clk;

	// ==========================================================
	// timeout
	// ==========================================================

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("run timed out after %0d cycles", cycles);
			$display("Checks failed");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// sn rises with the index, entry 2 is a branch and entry 6 is empty
	function automatic rob_img_t directed_rob();
		rob_img_t img;
		for (int i = 0; i < rob_n; i++) begin
			img[i].v = (i != 6);
			img[i].sn = 8'(i * 10);
			img[i].grp = 3'(i / 2);
			img[i].bno = 5'(i);
			img[i].is_br = (i == 2);
		end
		return img;
	endfunction

	// narrow group and branch fields make same-group and keep_bno hits likely
	task automatic fill_random_rob(output rob_img_t img);
		for (int i = 0; i < rob_n; i++) begin
			rng = xorshift(rng);
			img[i].v = rng[0] | rng[1];
			img[i].sn = rng[15:8];
			img[i].grp = {1'b0, rng[3:2]};
			img[i].bno = {2'b00, rng[18:16]};
			img[i].is_br = rng[4];
		end
	endtask

	// squash younger valid entries off the kept branch, sparing the
	// branch's own group whenever backout applies
	function automatic logic [rob_n-1:0] expected_map(input stomp_pkg::branch_state_t st,
			input stomp_pkg::miss_t m, input rob_img_t img);
		logic [rob_n-1:0] bits;
		stomp_pkg::rob_entry_t br;
		logic exempt;
		br = img[m.id];
		exempt = backout_on || (!m.taken && br.is_br);
		bits = '0;
		if (st == stomp_pkg::bs_restore || st == stomp_pkg::bs_done1) begin
			for (int i = 0; i < rob_n; i++) begin
				bits[i] = img[i].v && img[i].sn > br.sn && img[i].bno != m.keep_bno
					&& !(exempt && img[i].grp == br.grp);
			end
		end
		return bits;
	endfunction

	// ==========================================================
	// reference model
	// ==========================================================

	task automatic model_reset();
		m_state = stomp_pkg::bs_idle;
		m_ack = 1'b0;
		m_map = '0;
		m_flag = '1;
		m_tv = '0;
		for (int i = 0; i < stages; i++) begin
			m_tpc[i] = '0;
		end
		m_miss = '0;
	endtask

	// compares the outputs of this cycle, then moves the model over the next edge
	task automatic check_cycle();
		stomp_pkg::pc_t pcs [stages];
		logic [stages-1:0] exp_stomp;
		logic [stages-1:0] got_stomp;
		logic start;
		logic accept;
		pcs[0] = pc_fet;
		pcs[1] = pc_mux;
		pcs[2] = pc_dec;
		pcs[3] = pc_ren;
		// the restore state is the first cycle of recovery and stomps all stages
		start = m_state == stomp_pkg::bs_restore;
		for (int i = 0; i < stages; i++) begin
			exp_stomp[i] = start || (m_flag[i] && !(m_tv[i] && pcs[i] == m_tpc[i]));
		end
		got_stomp = {stomp_ren, stomp_dec, stomp_mux, stomp_fet};
		checks += 3;
		if (got_stomp !== exp_stomp) begin
			errors++;
			$display("[ERROR] %0t: stomp ren..fet %b, expected %b", $time, got_stomp, exp_stomp);
		end
		if (miss_ack !== m_ack) begin
			errors++;
			$display("[ERROR] %0t: miss_ack %b, expected %b", $time, miss_ack, m_ack);
		end
		if (rob_stomp_map !== m_map) begin
			errors++;
			$display("[ERROR] %0t: rob_stomp_map %b, expected %b", $time, rob_stomp_map, m_map);
		end
		// a new request counts only once the previous ack has dropped
		accept = miss_req && !m_ack && m_state == stomp_pkg::bs_idle;
		m_map = expected_map(m_state, m_miss, rob);
		if (start) begin
			m_flag = '1;
			m_tv = 4'b0001;
			m_tpc[0] = m_miss.target;
		end else if (advance) begin
			for (int i = stages - 1; i > 0; i--) begin
				m_flag[i] = exp_stomp[i-1];
				m_tv[i] = m_tv[i-1];
				m_tpc[i] = m_tpc[i-1];
			end
			m_flag[0] = 1'b0;
			m_tv[0] = 1'b0;
		end
		if (accept) begin
			m_ack = 1'b1;
		end else if (!miss_req) begin
			m_ack = 1'b0;
		end
		// one state per cycle through restore, done1 and done2 back to idle
		if (m_state != stomp_pkg::bs_idle) begin
			m_state = stomp_pkg::branch_state_t'(2'(m_state + 1));
		end else if (accept) begin
			m_state = stomp_pkg::bs_restore;
		end
		if (accept) begin
			m_miss = miss;
		end
	endtask

	// ==========================================================
	// stimulus
	// ==========================================================

	// the stage PCs move down the pipe only when the last step advanced
	task automatic step(input logic req, input logic adv, input stomp_pkg::pc_t fetch_pc);
		@(posedge clk);
		miss_req <= req;
		miss <= cur_miss;
		advance <= adv;
		rob <= cur_rob;
		if (shift_pcs) begin
			pc_ren <= pc_dec;
			pc_dec <= pc_mux;
			pc_mux <= pc_fet;
			pc_fet <= fetch_pc;
		end
		shift_pcs = adv;
		@(negedge clk);
		check_cycle();
	endtask

	// the report changes only while req and ack are both low
	task automatic request_miss(input stomp_pkg::miss_t m);
		while (miss_ack) begin
			step(1'b0, 1'b0, idle_pc);
		end
		cur_miss = m;
		step(1'b1, 1'b0, idle_pc);
		while (!miss_ack) begin
			step(1'b1, 1'b0, idle_pc);
		end
	endtask

	task automatic add_case(input stomp_pkg::pc_t target, input logic [2:0] id,
			input logic [4:0] keep, input logic taken, input logic rnd,
			input logic [7:0] adv, input logic [7:0] hit);
		case_t c;
		c.m.target = target;
		c.m.id = id;
		c.m.keep_bno = keep;
		c.m.taken = taken;
		c.rand_rob = rnd;
		c.adv = adv;
		c.hit = hit;
		table_q.push_back(c);
	endtask

	// the redirect refills fetch, so the first step always loads a new fetch PC
	task automatic run_case(input int n);
		case_t c;
		int errs_before;
		c = table_q[n];
		errs_before = errors;
		if (c.rand_rob) begin
			fill_random_rob(cur_rob);
		end else begin
			cur_rob = directed_rob();
		end
		request_miss(c.m);
		shift_pcs = 1'b1;
		for (int k = 0; k < 8; k++) begin
			step(1'b0, c.adv[k], c.hit[k] ? c.m.target : c.m.target + 32'd4);
		end
		$display("case %0d: target %h id %0d keep %0d taken %b, %0d errors", n,
			c.m.target, c.m.id, c.m.keep_bno, c.m.taken, errors - errs_before);
	endtask

	initial begin
		stomp_pkg::miss_t hs_miss;
		int first_ack;
		int errs_before;
		rst = 1'b1;
		miss_req = 1'b0;
		miss = '0;
		advance = 1'b0;
		pc_fet = idle_pc;
		pc_mux = idle_pc;
		pc_dec = idle_pc;
		pc_ren = idle_pc;
		rob = directed_rob();
		cur_rob = rob;
		cur_miss = '0;
		shift_pcs = 1'b0;
		// target, id, keep_bno, taken, random ROB, advance per step, fetch hit per step
		add_case(32'h0000_1000, 3'd2, 5'd5, 1'b1, 1'b0, 8'b1111_1111, 8'b0000_0001);
		add_case(32'h0000_2040, 3'd2, 5'd4, 1'b0, 1'b0, 8'b1111_1100, 8'b0000_0001);
		add_case(32'h0000_3ff0, 3'd5, 5'd3, 1'b1, 1'b1, 8'b1011_0111, 8'b0000_0010);
		add_case(32'h8000_0100, 3'd0, 5'd6, 1'b0, 1'b1, 8'b1111_1111, 8'b0000_0100);
		add_case(32'h0004_4444, 3'd7, 5'd0, 1'b1, 1'b1, 8'b1101_1011, 8'b0000_0001);
		add_case(32'h0000_0c00, 3'd2, 5'd1, 1'b0, 1'b0, 8'b0110_1101, 8'b0000_0011);
		limit = table_q.size() * 40 + 100;

		repeat (3) @(posedge clk);
		rst <= 1'b0;
		model_reset();

		// the empty pipe starts stomped and drains after four advances
		errs_before = errors;
		repeat (5) step(1'b0, 1'b1, idle_pc);
		checks++;
		if ({stomp_ren, stomp_dec, stomp_mux, stomp_fet} !== 4'b0000) begin
			errors++;
			$display("[ERROR] %0t: front end still stomped after four advances", $time);
		end
		$display("power-up: %0d errors", errors - errs_before);

		for (int n = 0; n < table_q.size(); n++) begin
			run_case(n);
		end

		// a second request raised as early as the handshake allows
		// must wait until the sequencer has gone idle
		// three recovery cycles and one accepting edge lie between the acks
		errs_before = errors;
		hs_miss = table_q[0].m;
		cur_rob = directed_rob();
		request_miss(hs_miss);
		first_ack = cycles;
		hs_miss.target = hs_miss.target + 32'h40;
		request_miss(hs_miss);
		checks++;
		if (cycles - first_ack != 4) begin
			errors++;
			$display("[ERROR] %0t: second ack %0d cycles after the first, expected 4",
				$time, cycles - first_ack);
		end
		repeat (6) step(1'b0, 1'b1, idle_pc);
		$display("handshake: %0d errors", errors - errs_before);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- vlog.f
verilog/stomp_pkg.sv
verilog/branch_recovery.sv
verilog/front_stomp.sv
verilog/rob_stomp.sv
verilog/stomp_unit.sv
testbench/stomp_tb.sv

//--- Bender.yml
package:
  name: stomp_unit

sources:
  # the package comes first, then the blocks and the top level
  - verilog/stomp_pkg.sv
  - verilog/branch_recovery.sv
  - verilog/front_stomp.sv
  - verilog/rob_stomp.sv
  - verilog/stomp_unit.sv
  - target: test
    files:
      - testbench/stomp_tb.sv
